// ==== vlog.f ====
rtl/stream_pkg.sv
rtl/sync_fifo.sv
rtl/stream_master.sv
rtl/stream_slave.sv
rtl/stream_loopback_top.sv
tests/stream_checker.sv
tests/tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the loopback testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"

// ==== tests/tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb;

	localparam int seed_init = 71;
	localparam int random_words = 512;
	localparam int overflow_writes = 70;
	localparam int timeout_cycles = 20000;
	localparam int storage_words = 2 * stream_pkg::fifo_depth;

	logic                               m00_axis_aclk;
	logic                               arst_n;
	logic                               wen;
	logic [stream_pkg::data_width-1:0] wdata;
	logic                               ren;
	logic [stream_pkg::data_width-1:0] rdata;
	logic                               r_ready;
	logic                               error_full;
	logic                               error_empty;
	logic [1:0]                         phase;

	int seed;
	int cycle_count = 0;
	int test_errors;
	int error_count;
	int full_seen;
	int empty_seen;
	int reads_checked;
	int rnd_writes;
	int rnd_reads;

	stream_loopback_top stream_loopback_top_inst (
		.m00_axis_aclk (m00_axis_aclk),
		.arst_n        (arst_n),
		.wen           (wen),
		.wdata         (wdata),
		.ren           (ren),
		.rdata         (rdata),
		.r_ready       (r_ready),
		.error_full    (error_full),
		.error_empty   (error_empty)
	);

	stream_checker stream_checker_inst (
		.m00_axis_aclk (m00_axis_aclk),
		.arst_n        (arst_n),
		.phase         (phase),
		.wen           (wen),
		.wdata         (wdata),
		.ren           (ren),
		.rdata         (rdata),
		.r_ready       (r_ready),
		.error_full    (error_full),
		.error_empty   (error_empty),
		.error_count   (error_count),
		.full_seen     (full_seen),
		.empty_seen    (empty_seen),
		.reads_checked (reads_checked)
	);

	always #5 m00_axis_aclk = ~m00_axis_aclk;

	always @(posedge m00_axis_aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic next_drive();
		@(posedge m00_axis_aclk);
		#1;                                                          // Inputs change after the edge.
	endtask

	task automatic read_packet();
		while (!r_ready)
			next_drive();
		ren = 1'b1;
		repeat (stream_pkg::packet_len) next_drive();
		ren = 1'b0;
	endtask

	task automatic expect_count(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", what, expected, actual);
			test_errors = test_errors + 1;
		end
	endtask

	task automatic produce_random();
		logic [31:0] r;
		while (rnd_writes < random_words) begin
			r = $random(seed);
			if (r[0] && (rnd_writes - rnd_reads) < storage_words) begin
				wen = 1'b1;
				wdata = $random(seed);
				rnd_writes = rnd_writes + 1;
			end else begin
				wen = 1'b0;
			end
			next_drive();
		end
		wen = 1'b0;
	endtask

	task automatic consume_packets();
		while (rnd_reads < random_words) begin
			read_packet();
			rnd_reads = rnd_reads + stream_pkg::packet_len;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		m00_axis_aclk = 1'b0;
		arst_n = 1'b0;
		wen = 1'b0;
		wdata = '0;
		ren = 1'b0;
		phase = 2'd0;
		seed = seed_init;
		test_errors = 0;
		rnd_writes = 0;
		rnd_reads = 0;
		repeat (5) next_drive();
		arst_n = 1'b1;
		next_drive();

		phase = 2'd1;                                                // Consumer stalled from reset.
		repeat (overflow_writes) begin
			wen = 1'b1;
			wdata = $random(seed);
			next_drive();
		end
		wen = 1'b0;
		repeat (2) next_drive();
		expect_count("overflow error_full pulses", overflow_writes - storage_words, full_seen);
		repeat (storage_words / stream_pkg::packet_len) read_packet();
		repeat (2) next_drive();

		phase = 2'd2;
		ren = 1'b1;
		next_drive();
		ren = 1'b0;
		repeat (2) next_drive();
		expect_count("underflow error_empty pulses", 1, empty_seen);

		phase = 2'd3;
		fork
			produce_random();
			consume_packets();
		join
		repeat (2) next_drive();
		expect_count("words read back", storage_words + random_words, reads_checked);

		$display("Errors: %0d checker, %0d test; error_full pulses %0d, error_empty pulses %0d",
			error_count, test_errors, full_seen, empty_seen);
		if (error_count == 0 && test_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/stream_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_checker (
	input  logic                               m00_axis_aclk,
	input  logic                               arst_n,
	input  logic [1:0]                         phase,
	input  logic                               wen,
	input  logic [stream_pkg::data_width-1:0] wdata,
	input  logic                               ren,
	input  logic [stream_pkg::data_width-1:0] rdata,
	input  logic                               r_ready,
	input  logic                               error_full,
	input  logic                               error_empty,
	output int                                 error_count,
	output int                                 full_seen,
	output int                                 empty_seen,
	output int                                 reads_checked
);

	localparam int settle_cycles = 48;                              // Worst packet trip with gaps.
	localparam int storage_words = 2 * stream_pkg::fifo_depth;

	logic [stream_pkg::data_width-1:0] model [$];
	logic [stream_pkg::data_width-1:0] exp_data;

	logic read_due;
	logic full_due;
	logic empty_due;

	int errors = 0;
	int words_in;
	int words_out;
	int avail;
	int stale_cycles;

	assign error_count = errors;

	function automatic string phase_name(input logic [1:0] p);
		case (p)
			2'd0:    return "reset";
			2'd1:    return "overflow";
			2'd2:    return "underflow";
			default: return "random";
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s %s: expected %h, actual %h at %0t",
			phase_name(phase), what, expected, actual, $time);
		errors = errors + 1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model and comparison
	//////////////////////////////////////////////////////////////////////

	always @(posedge m00_axis_aclk) begin
		if (!arst_n) begin
			if (r_ready || error_full || error_empty)
				report_mismatch("outputs in reset", 32'h0, {r_ready, error_full, error_empty});
			model.delete();
			read_due = 1'b0;
			full_due = 1'b0;
			empty_due = 1'b0;
			words_in = 0;
			words_out = 0;
			stale_cycles = 0;
			full_seen = 0;
			empty_seen = 0;
			reads_checked = 0;
		end else begin
			if (read_due && rdata !== exp_data)
				report_mismatch("read data", exp_data, rdata);
			if (error_full !== full_due)
				report_mismatch("error_full", {31'h0, full_due}, {31'h0, error_full});
			if (error_empty !== empty_due)
				report_mismatch("error_empty", {31'h0, empty_due}, {31'h0, error_empty});
			if (error_full)
				full_seen = full_seen + 1;
			if (error_empty)
				empty_seen = empty_seen + 1;

			// Whole packets written and not yet read back.
			avail = words_in / stream_pkg::packet_len - words_out / stream_pkg::packet_len;
			if (r_ready && avail < 1) begin
				$display("Pacing error in %s: r_ready is high with no whole packet unread at %0t",
					phase_name(phase), $time);
				errors = errors + 1;
			end
			if (!r_ready && avail >= 1)
				stale_cycles = stale_cycles + 1;
			else
				stale_cycles = 0;
			if (stale_cycles == settle_cycles) begin
				$display("Pacing error in %s: a whole packet waited %0d cycles without r_ready",
					phase_name(phase), settle_cycles);
				errors = errors + 1;
			end

			read_due = 1'b0;
			full_due = 1'b0;
			empty_due = 1'b0;
			if (ren) begin
				if (model.size() == 0) begin
					empty_due = 1'b1;                                 // Nothing stored to return.
				end else begin
					exp_data = model.pop_front();
					read_due = 1'b1;
					words_out = words_out + 1;
					reads_checked = reads_checked + 1;
				end
			end
			if (wen) begin
				if (model.size() >= storage_words) begin
					full_due = 1'b1;                                  // Both buffers are full.
				end else begin
					model.push_back(wdata);
					words_in = words_in + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stream_loopback_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_loopback_top (
	input  logic                               m00_axis_aclk,
	input  logic                               arst_n,
	input  logic                               wen,
	input  logic [stream_pkg::data_width-1:0] wdata,
	input  logic                               ren,
	output logic [stream_pkg::data_width-1:0] rdata,
	output logic                               r_ready,
	output logic                               error_full,
	output logic                               error_empty
);

	logic [stream_pkg::count_width-1:0] tx_count;
	logic [stream_pkg::data_width-1:0]  tx_head;
	logic                                tx_pop;
	logic                                tx_full;

	logic                               m00_axis_tvalid;
	logic [stream_pkg::data_width-1:0] m00_axis_tdata;
	logic                               m00_axis_tlast;
	logic                               m00_axis_tready;

	logic                               rx_push;
	logic [stream_pkg::data_width-1:0] rx_data;
	logic                               rx_full;
	logic                               rx_empty;

	//////////////////////////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////////////////////////

	sync_fifo tx_fifo (
		.m00_axis_aclk (m00_axis_aclk),
		.arst_n        (arst_n),
		.wr_en         (wen),
		.wr_data       (wdata),
		.rd_en         (tx_pop),
		.rd_data       (),
		.head          (tx_head),
		.count         (tx_count),
		.full          (tx_full),
		.empty         ()
	);

	stream_master stream_master_inst (
		.m00_axis_aclk   (m00_axis_aclk),
		.arst_n          (arst_n),
		.tx_count        (tx_count),
		.tx_head         (tx_head),
		.tx_pop          (tx_pop),
		.m00_axis_tvalid (m00_axis_tvalid),
		.m00_axis_tdata  (m00_axis_tdata),
		.m00_axis_tlast  (m00_axis_tlast),
		.m00_axis_tready (m00_axis_tready)
	);

	//////////////////////////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////////////////////////

	stream_slave stream_slave_inst (
		.m00_axis_aclk   (m00_axis_aclk),
		.arst_n          (arst_n),
		.s00_axis_tvalid (m00_axis_tvalid),
		.s00_axis_tdata  (m00_axis_tdata),
		.s00_axis_tlast  (m00_axis_tlast),
		.s00_axis_tready (m00_axis_tready),
		.rx_full         (rx_full),
		.rx_push         (rx_push),
		.rx_data         (rx_data),
		.ren             (ren),
		.rx_empty        (rx_empty),
		.r_ready         (r_ready)
	);

	sync_fifo rx_fifo (
		.m00_axis_aclk (m00_axis_aclk),
		.arst_n        (arst_n),
		.wr_en         (rx_push),
		.wr_data       (rx_data),
		.rd_en         (ren),
		.rd_data       (rdata),
		.head          (),
		.count         (),
		.full          (rx_full),
		.empty         (rx_empty)
	);

	// Each error shows for one cycle, the cycle after the bad strobe.
	always_ff @(posedge m00_axis_aclk or negedge arst_n) begin
		if (!arst_n) begin
			error_full  <= 1'b0;
			error_empty <= 1'b0;
		end else begin
			error_full  <= wen && tx_full;                            // The word was dropped.
			error_empty <= ren && rx_empty;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stream_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_slave (
	input  logic                               m00_axis_aclk,
	input  logic                               arst_n,
	input  logic                               s00_axis_tvalid,
	input  logic [stream_pkg::data_width-1:0] s00_axis_tdata,
	input  logic                               s00_axis_tlast,
	output logic                               s00_axis_tready,
	input  logic                               rx_full,
	output logic                               rx_push,
	output logic [stream_pkg::data_width-1:0] rx_data,
	input  logic                               ren,
	input  logic                               rx_empty,
	output logic                               r_ready
);

	logic [stream_pkg::pkt_count_width-1:0]  pkt_count;
	logic [stream_pkg::word_index_width-1:0] in_idx;              // Position of the next link word.
	logic [stream_pkg::word_index_width-1:0] rd_idx;              // Position of the next consumer read.

	logic rd_fire;
	logic pkt_in;
	logic pkt_out;

	assign s00_axis_tready = !rx_full;
	assign rx_push = s00_axis_tvalid && s00_axis_tready;
	assign rx_data = s00_axis_tdata;

	assign rd_fire = ren && !rx_empty;                              // Same rule the buffer applies.
	assign pkt_in  = rx_push && s00_axis_tlast;
	assign pkt_out = rd_fire &&
		(rd_idx == stream_pkg::word_index_width'(stream_pkg::packet_len - 1));

	assign r_ready = (pkt_count != '0);

	//////////////////////////////////////////////////////////////////////
	// Word positions on both sides of the receive buffer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge m00_axis_aclk or negedge arst_n) begin
		if (!arst_n) begin
			in_idx <= '0;
			rd_idx <= '0;
		end else begin
			if (rx_push)
				in_idx <= in_idx + 1'b1;                              // Packet length is a power of two.
			if (rd_fire)
				rd_idx <= rd_idx + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Whole packets held
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge m00_axis_aclk or negedge arst_n) begin
		if (!arst_n)
			pkt_count <= '0;
		else
			case ({pkt_in, pkt_out})
				2'b10:   pkt_count <= pkt_count + 1'b1;
				2'b01:   pkt_count <= pkt_count - 1'b1;
				default: pkt_count <= pkt_count;
			endcase
	end

	a_tlast_spacing: assert property (
		@(posedge m00_axis_aclk) disable iff (!arst_n)
		rx_push |->
			(s00_axis_tlast ==
			(in_idx == stream_pkg::word_index_width'(stream_pkg::packet_len - 1)))
	) else $error("stream_slave saw tlast off the packet boundary");

endmodule

`default_nettype wire

// ==== rtl/stream_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_master (
	input  logic                                m00_axis_aclk,
	input  logic                                arst_n,
	input  logic [stream_pkg::count_width-1:0] tx_count,
	input  logic [stream_pkg::data_width-1:0]  tx_head,
	output logic                                tx_pop,
	output logic                                m00_axis_tvalid,
	output logic [stream_pkg::data_width-1:0]  m00_axis_tdata,
	output logic                                m00_axis_tlast,
	input  logic                                m00_axis_tready
);

	logic                                     sending;               // Low is idle, high is send.
	logic [stream_pkg::word_index_width-1:0] word_idx;

	logic packet_ready;
	logic last_word;
	logic xfer;

	assign packet_ready = (tx_count >= stream_pkg::count_width'(stream_pkg::packet_len));
	assign last_word = (word_idx == stream_pkg::word_index_width'(stream_pkg::packet_len - 1));

	assign xfer = m00_axis_tvalid && m00_axis_tready;

	//////////////////////////////////////////////////////////////////////
	// Link outputs
	//////////////////////////////////////////////////////////////////////

	assign m00_axis_tvalid = sending;
	assign m00_axis_tdata  = tx_head;                                // Head only moves on a pop.
	assign m00_axis_tlast  = sending && last_word;
	assign tx_pop          = xfer;

	//////////////////////////////////////////////////////////////////////
	// Idle/send FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge m00_axis_aclk or negedge arst_n) begin
		if (!arst_n) begin
			sending  <= 1'b0;
			word_idx <= '0;
		end else if (!sending) begin
			if (packet_ready)
				sending <= 1'b1;                                      // A whole packet is buffered.
			word_idx <= '0;
		end else if (xfer) begin
			if (last_word) begin
				sending  <= 1'b0;                                     // Forces a gap cycle after tlast.
				word_idx <= '0;
			end else begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	// A stalled word must not change until the slave takes it.
	a_hold_stalled: assert property (
		@(posedge m00_axis_aclk) disable iff (!arst_n)
		m00_axis_tvalid && !m00_axis_tready |=>
			m00_axis_tvalid && $stable(m00_axis_tdata) && $stable(m00_axis_tlast)
	) else $error("stream_master changed a stalled word");

endmodule

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo (
	input  logic                                m00_axis_aclk,
	input  logic                                arst_n,
	input  logic                                wr_en,
	input  logic [stream_pkg::data_width-1:0]  wr_data,
	input  logic                                rd_en,
	output logic [stream_pkg::data_width-1:0]  rd_data,
	output logic [stream_pkg::data_width-1:0]  head,
	output logic [stream_pkg::count_width-1:0] count,
	output logic                                full,
	output logic                                empty
);

	logic [stream_pkg::data_width-1:0] mem [stream_pkg::fifo_depth];

	logic [stream_pkg::ptr_width-1:0] wr_ptr;
	logic [stream_pkg::ptr_width-1:0] rd_ptr;

	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;                                   // Writes into a full buffer are lost.
	assign do_rd = rd_en && !empty;

	assign full  = (count == stream_pkg::count_width'(stream_pkg::fifo_depth));
	assign empty = (count == '0);

	assign head = mem[rd_ptr];                                       // Show-ahead word for the master.

	//////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge m00_axis_aclk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;                              // Depth is a power of two, so it wraps.
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Storage and registered read port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge m00_axis_aclk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];                                  // Holds until the next good read.
	end

	a_count_bound: assert property (
		@(posedge m00_axis_aclk) disable iff (!arst_n)
		count <= stream_pkg::count_width'(stream_pkg::fifo_depth)
	) else $error("sync_fifo count beyond depth");

	// A full or empty buffer has its two pointers on the same slot.
	a_flag_pointers: assert property (
		@(posedge m00_axis_aclk) disable iff (!arst_n)
		(full || empty) |-> (wr_ptr == rd_ptr)
	) else $error("sync_fifo flags disagree with the pointers");

endmodule

`default_nettype wire

// ==== rtl/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

	//////////////////////////////////////////////////////////////////////
	// Stream word and packet shape
	//////////////////////////////////////////////////////////////////////

	localparam int data_width = 32;
	localparam int packet_len = 16;

	//////////////////////////////////////////////////////////////////////
	// Buffer sizing
	//////////////////////////////////////////////////////////////////////

	localparam int fifo_depth = 32;                                  // Two whole packets.

	localparam int ptr_width = $clog2(fifo_depth);
	localparam int count_width = $clog2(fifo_depth + 1);             // Must reach fifo_depth itself.

	// Number of whole packets a buffer can hold, plus the zero state.
	localparam int pkt_count_width = $clog2(fifo_depth / packet_len + 1);

	localparam int word_index_width = $clog2(packet_len);

endpackage

`default_nettype wire
